// File: list.f
src/noc_cfg_pkg.sv
src/noc_flit_pkg.sv
src/noc_in_port.sv
src/noc_switch_alloc.sv
src/noc_out_port.sv
src/noc_router.sv
src/noc_dummy_tile.sv
verif/noc_tile_properties.sv
verif/noc_checker.sv
verif/tb_noc_dummy_tile.sv

// File: run_sim.sh
#!/bin/sh
# Builds the dummy tile testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_noc_dummy_tile \
  -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "run_sim: build failed"
  exit 1
fi

./obj_dir/Vtb_noc_dummy_tile +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "run_sim: FAIL"
  exit 1
fi
echo "run_sim: PASS"
exit 0

// File: verif/tb_noc_dummy_tile.sv
/*
  Testbench for the dummy tile at (1,2). Each table row is one packet.
  The table runs twice. The second pass adds random output back-pressure.
  Rows marked par start together with the next row, on another port.
*/
module tb_noc_dummy_tile;

  localparam int NumRows   = 12;
  localparam int SendLimit = 300;   // cycles a flit may wait for ready
  localparam int DoneLimit = 3000;

  typedef struct packed {
    logic [1:0]  port;  // injecting mesh port, port_e order
    logic [1:0]  dx;
    logic [1:0]  dy;
    logic [3:0]  len;   // head included
    logic [15:0] base;
    logic        par;
  } row_t;

  // tile is (1,2); N=0 E=1 S=2 W=3
  row_t tbl [NumRows] = '{
    '{2'd3, 2'd3, 2'd0, 4'd3, 16'h1000, 1'b0},  // east
    '{2'd1, 2'd0, 2'd3, 4'd2, 16'h1100, 1'b0},  // west
    '{2'd0, 2'd1, 2'd3, 4'd4, 16'h1200, 1'b0},  // north
    '{2'd2, 2'd1, 2'd0, 4'd1, 16'h1300, 1'b0},  // south
    '{2'd3, 2'd1, 2'd2, 4'd3, 16'h1400, 1'b0},  // eject
    '{2'd0, 2'd1, 2'd2, 4'd1, 16'h1500, 1'b0},  // eject
    '{2'd3, 2'd2, 2'd2, 4'd4, 16'h1600, 1'b1},  // both to east
    '{2'd2, 2'd3, 2'd1, 4'd3, 16'h1700, 1'b0},
    '{2'd0, 2'd0, 2'd0, 4'd3, 16'h1800, 1'b1},  // both to west
    '{2'd1, 2'd0, 2'd2, 4'd2, 16'h1900, 1'b0},
    '{2'd2, 2'd1, 2'd3, 4'd2, 16'h1a00, 1'b1},  // both to north
    '{2'd1, 2'd1, 2'd3, 4'd3, 16'h1b00, 1'b0}
  };

  logic                         clk, rst_n, bp_en, end_chk, chk_done;
  noc_cfg_pkg::coord_t          tile_id;
  noc_flit_pkg::noc_fwd_t [3:0] link_in, link_out;
  noc_flit_pkg::noc_fwd_t       drv [4];
  logic [3:0]                   link_in_rdy, link_out_rdy;
  logic [15:0]                  eject_count;
  int unsigned                  chk_mism, chk_other, tb_errs, other_total;

  assign link_in = {drv[3], drv[2], drv[1], drv[0]};

  noc_dummy_tile uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .id_i          (tile_id),
    .mesh_fwd_i    (link_in),
    .mesh_rdy_o    (link_in_rdy),
    .mesh_fwd_o    (link_out),
    .mesh_rdy_i    (link_out_rdy),
    .eject_count_o (eject_count)
  );

  noc_checker chk (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .id_i          (tile_id),
    .in_fwd_i      (link_in),
    .in_rdy_i      (link_in_rdy),
    .out_fwd_i     (link_out),
    .out_rdy_i     (link_out_rdy),
    .eject_count_i (eject_count),
    .end_i         (end_chk),
    .done_o        (chk_done),
    .mismatch_o    (chk_mism),
    .other_o       (chk_other)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // output back-pressure, about one stall in four when enabled
  initial begin
    void'($urandom(32'hc31cf1ce));
    link_out_rdy = '1;
    forever begin
      @(negedge clk);
      for (int p = 0; p < 4; p++) link_out_rdy[p] = !bp_en || ($urandom % 4 != 0);
    end
  end

  function automatic noc_flit_pkg::noc_flit_t build_flit(row_t r, int k, int tag_id);
    noc_flit_pkg::noc_flit_t f;
    f.word.hdr.dst.x = r.dx;
    f.word.hdr.dst.y = r.dy;
    f.word.hdr.src   = '0;
    f.word.hdr.tag   = {1'b0, r.port, 5'(tag_id)};
    if (k > 0) f.word.data = r.base + 16'(k);  // body and tail carry data
    f.last = (k == int'(r.len) - 1);
    return f;
  endfunction

  task automatic send_packet(input int idx, input int pass);
    row_t r;
    int   cyc;
    r = tbl[idx];
    for (int k = 0; k < int'(r.len); k++) begin
      drv[r.port].valid = 1'b1;
      drv[r.port].flit  = build_flit(r, k, pass * 16 + idx);
      cyc = 0;
      while (!link_in_rdy[r.port] && cyc < SendLimit) begin
        @(negedge clk);
        cyc++;
      end
      if (!link_in_rdy[r.port]) begin
        $display("ERROR: input %0d never became ready, packet %0d abandoned", r.port, idx);
        tb_errs++;
        drv[r.port].valid = 1'b0;
        return;
      end
      @(negedge clk);  // transfer happened on the rising edge in between
    end
    drv[r.port].valid = 1'b0;
  endtask

  initial begin
    int r;
    int cyc;
    rst_n   = 1'b0;
    tile_id = '{x: 2'd1, y: 2'd2};
    bp_en   = 1'b0;
    end_chk = 1'b0;
    tb_errs = 0;
    for (int p = 0; p < 4; p++) drv[p] = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int pass = 0; pass < 2; pass++) begin
      bp_en = (pass == 1);
      r = 0;
      while (r < NumRows) begin
        if (tbl[r].par) begin
          fork
            send_packet(r, pass);
            send_packet(r + 1, pass);
          join
          r += 2;
        end else begin
          send_packet(r, pass);
          r++;
        end
      end
    end
    bp_en   = 1'b0;
    end_chk = 1'b1;
    cyc = 0;
    while (!chk_done && cyc < DoneLimit) begin
      @(negedge clk);
      cyc++;
    end
    if (!chk_done) begin
      $display("ERROR: checker did not finish draining");
      tb_errs++;
    end
    other_total = chk_other + tb_errs + uut.i_router.i_props.fail_cnt;
    $display("error counts: %0d mismatches, %0d other failures", chk_mism, other_total);
    if (chk_mism == 0 && other_total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verif/noc_checker.sv
/*
  Scoreboard for the dummy tile. Predicts each packet's output by XY order
  and matches output flits against the queue of the injecting port,
  which tag bits [7:5] name. The tile id must not change during a run.
*/
module noc_checker (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  noc_cfg_pkg::coord_t                                    id_i,
  input  noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumMeshPorts-1:0] in_fwd_i,
  input  logic                   [noc_cfg_pkg::NumMeshPorts-1:0] in_rdy_i,
  input  noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumMeshPorts-1:0] out_fwd_i,
  input  logic                   [noc_cfg_pkg::NumMeshPorts-1:0] out_rdy_i,
  input  logic                   [15:0]                          eject_count_i,
  input  logic                                                   end_i,
  output logic                                                   done_o,
  output int unsigned                                            mismatch_o,
  output int unsigned                                            other_o
);

  localparam int unsigned DrainLimit = 1000;

  noc_flit_pkg::noc_flit_t exp_q [16][$];  // index src*4 + out
  logic [3:0]              in_open, out_open;
  int unsigned             in_out [4];
  int unsigned             out_src [4];
  logic [15:0]             eject_exp;
  int unsigned             drain_cyc;
  logic                    first_q;

  // x is resolved before y
  function automatic int unsigned xy_output(noc_cfg_pkg::coord_t dst,
                                            noc_cfg_pkg::coord_t here);
    if (dst.x > here.x) return noc_cfg_pkg::East;
    if (dst.x < here.x) return noc_cfg_pkg::West;
    if (dst.y > here.y) return noc_cfg_pkg::North;
    if (dst.y < here.y) return noc_cfg_pkg::South;
    return noc_cfg_pkg::Eject;
  endfunction

  always @(posedge clk_i) begin
    noc_flit_pkg::noc_flit_t f;
    int unsigned             q;
    int unsigned             left;
    if (!rst_n_i) begin
      in_open    = '0;
      out_open   = '0;
      eject_exp  = '0;
      drain_cyc  = 0;
      done_o     = 1'b0;
      mismatch_o = 0;
      other_o    = 0;
      first_q    = 1'b1;
    end else begin
      if (first_q) begin
        for (int o = 0; o < 4; o++) begin
          if (out_fwd_i[o].valid) begin
            $display("MISMATCH at %0t: output %0d valid right after reset", $time, o);
            mismatch_o++;
          end
        end
        if (eject_count_i != '0) begin
          $display("MISMATCH at %0t: eject count %0d after reset", $time, eject_count_i);
          mismatch_o++;
        end
        first_q = 1'b0;
      end
      for (int p = 0; p < 4; p++) begin
        if (in_fwd_i[p].valid && in_rdy_i[p]) begin
          f = in_fwd_i[p].flit;
          if (!in_open[p]) in_out[p] = xy_output(f.word.hdr.dst, id_i);
          in_open[p] = !f.last;
          if (in_out[p] == noc_cfg_pkg::Eject) eject_exp++;
          else exp_q[p * 4 + in_out[p]].push_back(f);
        end
      end
      for (int o = 0; o < 4; o++) begin
        if (out_fwd_i[o].valid && out_rdy_i[o]) begin
          f = out_fwd_i[o].flit;
          if (!out_open[o]) out_src[o] = f.word.hdr.tag[7:5];  // head names its source
          out_open[o] = !f.last;
          q = out_src[o] * 4 + o;
          if (out_src[o] > 3 || exp_q[q].size() == 0) begin
            $display("MISMATCH at %0t: unexpected flit %h on output %0d", $time, f, o);
            mismatch_o++;
          end else begin
            if (exp_q[q][0] != f) begin
              $display("MISMATCH at %0t: output %0d got %h, expected %h",
                       $time, o, f, exp_q[q][0]);
              mismatch_o++;
            end
            void'(exp_q[q].pop_front());
          end
        end
      end
      if (end_i && !done_o) begin
        left = 0;
        for (int i = 0; i < 16; i++) left += exp_q[i].size();
        if (left == 0 && eject_count_i == eject_exp) begin
          done_o = 1'b1;
        end else if (drain_cyc == DrainLimit) begin
          if (left != 0) begin
            $display("ERROR: %0d flits never left the tile", left);
            other_o++;
          end
          if (eject_count_i != eject_exp) begin
            $display("MISMATCH at %0t: eject count %0d, expected %0d",
                     $time, eject_count_i, eject_exp);
            mismatch_o++;
          end
          done_o = 1'b1;
        end
        drain_cyc++;
      end
    end
  end

endmodule

// File: verif/noc_tile_properties.sv
/*
  Concurrent checks bound into noc_router.
  FIFO fill is rebuilt from push and pop and needs a clean reset.
*/
module noc_tile_properties (
  input logic                                               clk_i,
  input logic                                               rst_n_i,
  input noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumPorts-1:0] in_fwd_i,
  input logic                   [noc_cfg_pkg::NumPorts-1:0] in_rdy_i,
  input logic                   [noc_cfg_pkg::NumPorts-1:0] in_valid_i,
  input logic                   [noc_cfg_pkg::NumPorts-1:0] grant_i,
  input noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumPorts-1:0] out_fwd_i,
  input logic                   [noc_cfg_pkg::NumPorts-1:0] out_rdy_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far
  int unsigned fill_q [noc_cfg_pkg::NumPorts];

  always @(posedge clk_i) begin
    for (int p = 0; p < noc_cfg_pkg::NumPorts; p++) begin
      if (!rst_n_i) fill_q[p] <= 0;
      else fill_q[p] <= fill_q[p] + ((in_fwd_i[p].valid && in_rdy_i[p]) ? 1 : 0)
                                  - ((in_valid_i[p] && grant_i[p]) ? 1 : 0);
    end
  end

  for (genvar p = 0; p < noc_cfg_pkg::NumPorts; p++) begin : gen_port
    a_rst_idle: assert property (@(posedge clk_i) !rst_n_i |=> !out_fwd_i[p].valid)
      else begin
        $error("output %0d valid after reset", p);
        fail_cnt++;
      end
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_fwd_i[p].valid && !out_rdy_i[p] |=> out_fwd_i[p].valid && $stable(out_fwd_i[p].flit))
      else begin
        $error("output %0d changed while stalled", p);
        fail_cnt++;
      end
    a_no_overfill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(in_rdy_i[p] && fill_q[p] == noc_cfg_pkg::FifoDepth))
      else begin
        $error("input %0d ready with full FIFO", p);
        fail_cnt++;
      end
  end

endmodule

bind noc_router noc_tile_properties i_props (
  .clk_i,
  .rst_n_i,
  .in_fwd_i   (fwd_i),
  .in_rdy_i   (rdy_o),
  .in_valid_i (in_valid),
  .grant_i    (grant),
  .out_fwd_i  (fwd_o),
  .out_rdy_i  (rdy_i)
);

// File: src/noc_dummy_tile.sv
/*
  Dummy mesh tile: a router that only forwards traffic.
  Local inject is never valid. Flits for this tile are dropped at eject
  and counted. eject_count_o wraps at 16 bits.
*/
module noc_dummy_tile (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  noc_cfg_pkg::coord_t                                    id_i,
  input  noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumMeshPorts-1:0] mesh_fwd_i,
  output logic                   [noc_cfg_pkg::NumMeshPorts-1:0] mesh_rdy_o,
  output noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumMeshPorts-1:0] mesh_fwd_o,
  input  logic                   [noc_cfg_pkg::NumMeshPorts-1:0] mesh_rdy_i,
  output logic                   [15:0]                          eject_count_o
);

  noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumPorts-1:0] rtr_fwd_in, rtr_fwd_out;
  logic                   [noc_cfg_pkg::NumPorts-1:0] rtr_rdy_in, rtr_rdy_out;

  noc_router i_router (
    .clk_i,
    .rst_n_i,
    .tile_id_i (id_i),
    .fwd_i     (rtr_fwd_in),
    .rdy_o     (rtr_rdy_out),
    .fwd_o     (rtr_fwd_out),
    .rdy_i     (rtr_rdy_in)
  );

  assign rtr_fwd_in[noc_cfg_pkg::NumMeshPorts-1:0] = mesh_fwd_i;
  assign rtr_fwd_in[noc_cfg_pkg::Eject]            = '0;  // nothing to inject
  assign mesh_rdy_o = rtr_rdy_out[noc_cfg_pkg::NumMeshPorts-1:0];

  assign mesh_fwd_o = rtr_fwd_out[noc_cfg_pkg::NumMeshPorts-1:0];
  assign rtr_rdy_in[noc_cfg_pkg::NumMeshPorts-1:0] = mesh_rdy_i;
  assign rtr_rdy_in[noc_cfg_pkg::Eject]            = 1'b1;  // sink always accepts

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eject_count_o <= '0;
    end else if (rtr_fwd_out[noc_cfg_pkg::Eject].valid) begin
      eject_count_o <= eject_count_o + 1'b1;
    end
  end

endmodule

// File: src/noc_router.sv
/*
  Five-port wormhole router, XY routing, no virtual channels.
  Port index follows noc_cfg_pkg::port_e. Latency is 2 cycles without contention.
*/
module noc_router (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  noc_cfg_pkg::coord_t                                tile_id_i,
  input  noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumPorts-1:0] fwd_i,
  output logic                   [noc_cfg_pkg::NumPorts-1:0] rdy_o,
  output noc_flit_pkg::noc_fwd_t [noc_cfg_pkg::NumPorts-1:0] fwd_o,
  input  logic                   [noc_cfg_pkg::NumPorts-1:0] rdy_i
);

  noc_flit_pkg::noc_flit_t  [noc_cfg_pkg::NumPorts-1:0] in_flit;
  noc_flit_pkg::noc_route_t [noc_cfg_pkg::NumPorts-1:0] in_route;
  logic                     [noc_cfg_pkg::NumPorts-1:0] in_valid, grant;
  noc_flit_pkg::noc_fwd_t   [noc_cfg_pkg::NumPorts-1:0] alloc_fwd;
  logic                     [noc_cfg_pkg::NumPorts-1:0] alloc_rdy;

  for (genvar p = 0; p < noc_cfg_pkg::NumPorts; p++) begin : gen_in_port
    noc_in_port i_in_port (
      .clk_i,
      .rst_n_i,
      .tile_id_i,
      .fwd_i   (fwd_i[p]),
      .rdy_o   (rdy_o[p]),
      .flit_o  (in_flit[p]),
      .valid_o (in_valid[p]),
      .route_o (in_route[p]),
      .grant_i (grant[p])
    );
  end

  noc_switch_alloc i_alloc (
    .clk_i,
    .rst_n_i,
    .in_flit_i  (in_flit),
    .in_valid_i (in_valid),
    .in_route_i (in_route),
    .grant_o    (grant),
    .out_fwd_o  (alloc_fwd),
    .out_rdy_i  (alloc_rdy)
  );

  for (genvar p = 0; p < noc_cfg_pkg::NumPorts; p++) begin : gen_out_port
    noc_out_port i_out_port (
      .clk_i,
      .rst_n_i,
      .fwd_i (alloc_fwd[p]),
      .rdy_o (alloc_rdy[p]),
      .fwd_o (fwd_o[p]),
      .rdy_i (rdy_i[p])
    );
  end

endmodule

// File: src/noc_out_port.sv
/*
  Router output stage: one register between allocator and link.
  Full throughput, a new flit is taken in the cycle the old one drains.
*/
module noc_out_port (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  noc_flit_pkg::noc_fwd_t fwd_i,
  output logic                   rdy_o,
  output noc_flit_pkg::noc_fwd_t fwd_o,
  input  logic                   rdy_i
);

  logic                    valid_q;
  noc_flit_pkg::noc_flit_t flit_q;

  assign rdy_o = !valid_q || rdy_i;  // empty or draining

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (rdy_o) begin
      valid_q <= fwd_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdy_o && fwd_i.valid) flit_q <= fwd_i.flit;
  end

  assign fwd_o.valid = valid_q;
  assign fwd_o.flit  = flit_q;

endmodule

// File: src/noc_switch_alloc.sv
/*
  Switch allocator: per output, round-robin among requesting inputs.
  A winning head locks the output until its tail flit transfers.
  Valid toward an output stage is shown only when that stage is ready.
*/
module noc_switch_alloc (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  noc_flit_pkg::noc_flit_t  [noc_cfg_pkg::NumPorts-1:0] in_flit_i,
  input  logic                     [noc_cfg_pkg::NumPorts-1:0] in_valid_i,
  input  noc_flit_pkg::noc_route_t [noc_cfg_pkg::NumPorts-1:0] in_route_i,
  output logic                     [noc_cfg_pkg::NumPorts-1:0] grant_o,
  output noc_flit_pkg::noc_fwd_t   [noc_cfg_pkg::NumPorts-1:0] out_fwd_o,
  input  logic                     [noc_cfg_pkg::NumPorts-1:0] out_rdy_i
);

  logic                   [noc_cfg_pkg::NumPorts-1:0] req [noc_cfg_pkg::NumPorts];
  logic                   [noc_cfg_pkg::NumPorts-1:0] lock_q, sel_vld, xfer;
  noc_cfg_pkg::port_idx_t                             holder_q [noc_cfg_pkg::NumPorts];
  noc_cfg_pkg::port_idx_t                             rr_q     [noc_cfg_pkg::NumPorts];
  noc_cfg_pkg::port_idx_t                             sel      [noc_cfg_pkg::NumPorts];

  // req[o][i]: input i wants output o
  always_comb begin
    for (int o = 0; o < noc_cfg_pkg::NumPorts; o++) begin
      for (int i = 0; i < noc_cfg_pkg::NumPorts; i++) begin
        req[o][i] = in_valid_i[i] && in_route_i[i][o];
      end
    end
  end

  always_comb begin
    int unsigned idx;
    idx = 0;
    for (int o = 0; o < noc_cfg_pkg::NumPorts; o++) begin
      sel[o]     = '0;
      sel_vld[o] = 1'b0;
      if (lock_q[o]) begin
        sel[o]     = holder_q[o];  // wormhole, body waits for its own input
        sel_vld[o] = req[o][holder_q[o]];
      end else begin
        for (int k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
          idx = (int'(rr_q[o]) + k) % noc_cfg_pkg::NumPorts;
          if (!sel_vld[o] && req[o][idx]) begin
            sel[o]     = noc_cfg_pkg::port_idx_t'(idx);
            sel_vld[o] = 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    grant_o = '0;
    for (int o = 0; o < noc_cfg_pkg::NumPorts; o++) begin
      xfer[o]            = sel_vld[o] && out_rdy_i[o];
      out_fwd_o[o].valid = xfer[o];
      out_fwd_o[o].flit  = in_flit_i[sel[o]];
      if (xfer[o]) grant_o[sel[o]] = 1'b1;  // route is one-hot, at most one hit
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q   <= '0;
      holder_q <= '{default: '0};
      rr_q     <= '{default: '0};
    end else begin
      for (int o = 0; o < noc_cfg_pkg::NumPorts; o++) begin
        if (xfer[o]) begin
          if (in_flit_i[sel[o]].last) begin
            lock_q[o] <= 1'b0;
            // priority moves past the winner once its packet is done
            rr_q[o]   <= (sel[o] == noc_cfg_pkg::port_idx_t'(noc_cfg_pkg::NumPorts - 1)) ?
                         '0 : sel[o] + 1'b1;
          end else begin
            lock_q[o]   <= 1'b1;
            holder_q[o] <= sel[o];
          end
        end
      end
    end
  end

endmodule

// File: src/noc_in_port.sv
/*
  Router input port: small FIFO plus XY route computation.
  The route is decoded from the head flit and held until the tail is granted.
  Ready depends only on FIFO fill. A pop in the same cycle does not raise it.
*/
module noc_in_port (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  noc_cfg_pkg::coord_t      tile_id_i,
  input  noc_flit_pkg::noc_fwd_t   fwd_i,
  output logic                     rdy_o,
  output noc_flit_pkg::noc_flit_t  flit_o,
  output logic                     valid_o,
  output noc_flit_pkg::noc_route_t route_o,
  input  logic                     grant_i
);

  noc_flit_pkg::noc_flit_t  mem_q [noc_cfg_pkg::FifoDepth];
  noc_cfg_pkg::fifo_ptr_t   wr_ptr_q, rd_ptr_q;
  noc_cfg_pkg::fifo_cnt_t   fill_q;
  logic                     push, pop, full;
  logic                     in_pkt_q;  // head granted, tail still pending
  noc_flit_pkg::noc_route_t route_q, route_dec;
  noc_cfg_pkg::coord_t      dst;

  assign full    = (fill_q == noc_cfg_pkg::fifo_cnt_t'(noc_cfg_pkg::FifoDepth));
  assign rdy_o   = !full;
  assign push    = fwd_i.valid && rdy_o;
  assign valid_o = (fill_q != '0);
  assign pop     = valid_o && grant_i;
  assign flit_o  = mem_q[rd_ptr_q];

  // header view only makes sense while no packet is open
  assign dst = flit_o.word.hdr.dst;

  // dimension order: x first, then y
  always_comb begin
    route_dec = '0;
    if (dst.x > tile_id_i.x)      route_dec[noc_cfg_pkg::East]  = 1'b1;
    else if (dst.x < tile_id_i.x) route_dec[noc_cfg_pkg::West]  = 1'b1;
    else if (dst.y > tile_id_i.y) route_dec[noc_cfg_pkg::North] = 1'b1;
    else if (dst.y < tile_id_i.y) route_dec[noc_cfg_pkg::South] = 1'b1;
    else                          route_dec[noc_cfg_pkg::Eject] = 1'b1;
  end

  assign route_o = in_pkt_q ? route_q : route_dec;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      in_pkt_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == noc_cfg_pkg::FifoDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == noc_cfg_pkg::FifoDepth - 1) ? '0 : rd_ptr_q + 1'b1;
        in_pkt_q <= !flit_o.last;  // single-flit packets never open
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // latch route as the head leaves
  always_ff @(posedge clk_i) begin
    if (pop && !in_pkt_q) route_q <= route_dec;
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= fwd_i.flit;
  end

endmodule

// File: src/noc_flit_pkg.sv
/*
  Flit format for the single narrow channel.
  Only the first flit of a packet carries a header. Later flits are raw data.
  Tag bits [7:5] name the injecting port. The router does not read them.
*/
package noc_flit_pkg;

  localparam int unsigned PayloadW = 16;

  typedef struct packed {
    noc_cfg_pkg::coord_t dst;
    noc_cfg_pkg::coord_t src;
    logic [7:0]          tag;
  } noc_hdr_t;

  // same 16 bits, two views
  typedef union packed {
    noc_hdr_t            hdr;   // head flit
    logic [PayloadW-1:0] data;  // body and tail flits
  } noc_word_u;

  typedef struct packed {
    noc_word_u word;
    logic      last;  // tail marker
  } noc_flit_t;

  // forward half of a link; ready travels back on its own wire
  typedef struct packed {
    logic      valid;
    noc_flit_t flit;
  } noc_fwd_t;

  // one-hot output port, indexed by noc_cfg_pkg::port_e
  typedef logic [noc_cfg_pkg::NumPorts-1:0] noc_route_t;

endpackage

// File: src/noc_cfg_pkg.sv
/*
  Mesh topology for the dummy tile: 4x4 mesh, five router ports.
  Port order is fixed. The mesh ports come first and Eject is last.
*/
package noc_cfg_pkg;

  localparam int unsigned CoordW       = 2;  // 4x4 mesh
  localparam int unsigned NumPorts     = 5;
  localparam int unsigned NumMeshPorts = 4;
  localparam int unsigned FifoDepth    = 2;  // per input port

  localparam int unsigned FifoPtrW = $clog2(FifoDepth);
  localparam int unsigned FifoCntW = $clog2(FifoDepth + 1);
  localparam int unsigned PortIdxW = $clog2(NumPorts);

  typedef struct packed {
    logic [CoordW-1:0] x;
    logic [CoordW-1:0] y;
  } coord_t;

  // north = +y, east = +x
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } port_e;

  typedef logic [FifoPtrW-1:0] fifo_ptr_t;
  typedef logic [FifoCntW-1:0] fifo_cnt_t;
  typedef logic [PortIdxW-1:0] port_idx_t;

endpackage
